// ==== Makefile ====
# Verilator build and run of the TCDM interconnect testbench

SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_soc_interconnect
FILELIST  = compile.f
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) design/soc_interconnect_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+design
design/soc_interconnect_pkg.sv
design/tcdm_addr_decoder.sv
design/tcdm_error_slave.sv
design/tcdm_demux.sv
design/tcdm_crossbar.sv
design/soc_interconnect.sv
testbench/tb_clock_gen.sv
testbench/tb_soc_interconnect.sv

// ==== design/soc_interconnect.sv ====
// TCDM interconnect top joining the region demultiplexers, both crossbars and the gap error slave

`timescale 1ns/1ps

`include "soc_interconnect_params.svh"

module soc_interconnect (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t master_req_i     [`SOC_NR_MASTERS],
    output soc_interconnect_pkg::tcdm_rsp_t master_rsp_o     [`SOC_NR_MASTERS],
    input  soc_interconnect_pkg::tcdm_req_t intlv_only_req_i [`SOC_NR_INTLV_ONLY],
    output soc_interconnect_pkg::tcdm_rsp_t intlv_only_rsp_o [`SOC_NR_INTLV_ONLY],
    output soc_interconnect_pkg::tcdm_req_t bank_req_o       [`SOC_NR_BANKS],
    input  soc_interconnect_pkg::tcdm_rsp_t bank_rsp_i       [`SOC_NR_BANKS],
    output soc_interconnect_pkg::tcdm_req_t contig_req_o     [`SOC_NR_CONTIG],
    input  soc_interconnect_pkg::tcdm_rsp_t contig_rsp_i     [`SOC_NR_CONTIG]
);

    // Full-access demuxes take the low lanes and interleaved-only demuxes follow
    localparam int unsigned NR_LANES = `SOC_NR_MASTERS + `SOC_NR_INTLV_ONLY;

    soc_interconnect_pkg::tcdm_req_t   intlv_req   [NR_LANES];
    soc_interconnect_pkg::tcdm_rsp_t   intlv_rsp   [NR_LANES];
    logic [1:0]                        intlv_sel   [NR_LANES];
    soc_interconnect_pkg::tcdm_req_t   contig_req  [NR_LANES];
    soc_interconnect_pkg::tcdm_rsp_t   contig_rsp  [NR_LANES];
    soc_interconnect_pkg::contig_sel_e contig_sel  [NR_LANES];
    logic [1:0]                        contig_bits [NR_LANES];
    soc_interconnect_pkg::tcdm_req_t   cxbar_req   [`SOC_NR_CONTIG+1];
    soc_interconnect_pkg::tcdm_rsp_t   cxbar_rsp   [`SOC_NR_CONTIG+1];

    ////////////////////////////////////////
    // Region demultiplexers
    ////////////////////////////////////////

    for (genvar i = 0; i < `SOC_NR_MASTERS; i++) begin : gen_demux
        tcdm_demux #(
            .ALLOW_CONTIG (1'b1)
        ) i_demux (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .master_req_i (master_req_i[i]),
            .master_rsp_o (master_rsp_o[i]),
            .intlv_req_o  (intlv_req[i]),
            .intlv_rsp_i  (intlv_rsp[i]),
            .contig_req_o (contig_req[i]),
            .contig_sel_o (contig_sel[i]),
            .contig_rsp_i (contig_rsp[i])
        );
    end

    // These lanes never raise req towards the contiguous crossbar
    for (genvar j = 0; j < `SOC_NR_INTLV_ONLY; j++) begin : gen_intlv_only_demux
        tcdm_demux #(
            .ALLOW_CONTIG (1'b0)
        ) i_demux (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .master_req_i (intlv_only_req_i[j]),
            .master_rsp_o (intlv_only_rsp_o[j]),
            .intlv_req_o  (intlv_req[`SOC_NR_MASTERS+j]),
            .intlv_rsp_i  (intlv_rsp[`SOC_NR_MASTERS+j]),
            .contig_req_o (contig_req[`SOC_NR_MASTERS+j]),
            .contig_sel_o (contig_sel[`SOC_NR_MASTERS+j]),
            .contig_rsp_i (contig_rsp[`SOC_NR_MASTERS+j])
        );
    end

    // Bank select is the two lowest word-address bits
    for (genvar i = 0; i < NR_LANES; i++) begin : gen_sel
        assign intlv_sel[i]   = intlv_req[i].add[3:2];
        assign contig_bits[i] = contig_sel[i];
    end

    ////////////////////////////////////////
    // Crossbars
    ////////////////////////////////////////

    tcdm_crossbar #(
        .NR_MASTERS (NR_LANES),
        .NR_SLAVES  (`SOC_NR_BANKS)
    ) i_intlv_xbar (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (intlv_req),
        .master_sel_i (intlv_sel),
        .master_rsp_o (intlv_rsp),
        .slave_req_o  (bank_req_o),
        .slave_rsp_i  (bank_rsp_i)
    );

    // The slot after the ranged slaves takes every gap address
    tcdm_crossbar #(
        .NR_MASTERS (NR_LANES),
        .NR_SLAVES  (`SOC_NR_CONTIG + 1)
    ) i_contig_xbar (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .master_req_i (contig_req),
        .master_sel_i (contig_bits),
        .master_rsp_o (contig_rsp),
        .slave_req_o  (cxbar_req),
        .slave_rsp_i  (cxbar_rsp)
    );

    for (genvar i = 0; i < `SOC_NR_CONTIG; i++) begin : gen_contig_port
        assign contig_req_o[i] = cxbar_req[i];
        assign cxbar_rsp[i]    = contig_rsp_i[i];
    end

    tcdm_error_slave i_gap_error_slave (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .slave_req_i (cxbar_req[`SOC_NR_CONTIG]),
        .slave_rsp_o (cxbar_rsp[`SOC_NR_CONTIG])
    );

endmodule

// ==== design/soc_interconnect_params.svh ====
// Interconnect parameters covering bus widths, port counts, the fixed address map and the error word

`ifndef SOC_INTERCONNECT_PARAMS_SVH
`define SOC_INTERCONNECT_PARAMS_SVH

// One TCDM word carries 32 data bits and uses a 32-bit byte address
`define SOC_DATA_WIDTH 32
`define SOC_ADDR_WIDTH 32

// Masters that may reach every region, and masters limited to the interleaved region
`define SOC_NR_MASTERS    2
`define SOC_NR_INTLV_ONLY 1

// Interleaved banks and address-ranged contiguous slaves
`define SOC_NR_BANKS  4
`define SOC_NR_CONTIG 2

////////////////////////////////////////
// Fixed address map
////////////////////////////////////////

`define SOC_INTLV_START   32'h1C00_0000
`define SOC_INTLV_END     32'h1C00_FFFF
`define SOC_CONTIG_START  32'h1C01_0000
`define SOC_CONTIG_END    32'h1C01_FFFF
`define SOC_CONTIG0_START 32'h1C01_0000
`define SOC_CONTIG0_END   32'h1C01_3FFF
`define SOC_CONTIG1_START 32'h1C01_4000
`define SOC_CONTIG1_END   32'h1C01_7FFF

// Read data returned by every error slave
`define SOC_ERROR_WORD 32'hBADA_CCE5

`endif

// ==== design/soc_interconnect_pkg.sv ====
// Shared TCDM bus structs and the region and contiguous routing enums of the interconnect

`include "soc_interconnect_params.svh"

package soc_interconnect_pkg;

    ////////////////////////////////////////
    // TCDM bus
    ////////////////////////////////////////

    // Request half of a link that the requester drives and holds until gnt
    typedef struct packed {
        logic                         req;
        logic [`SOC_ADDR_WIDTH-1:0]   add;
        logic                         wen;   // High for a read
        logic [`SOC_DATA_WIDTH/8-1:0] be;
        logic [`SOC_DATA_WIDTH-1:0]   wdata;
    } tcdm_req_t;

    // Response half of a link where gnt is combinational and the rest follows one cycle later
    typedef struct packed {
        logic                       gnt;
        logic                       r_valid;
        logic                       r_opc;   // High on an error response
        logic [`SOC_DATA_WIDTH-1:0] r_rdata;
    } tcdm_rsp_t;

    ////////////////////////////////////////
    // Routing
    ////////////////////////////////////////

    // Region of the map that a request address falls into
    typedef enum logic [1:0] {
        REGION_ERROR,
        REGION_CONTIG,
        REGION_INTLV
    } region_e;

    // The values double as slave indices on the contiguous crossbar
    // The gap entry is the error slave that sits behind the two ranged slaves
    typedef enum logic [1:0] {
        CONTIG_SLAVE0,
        CONTIG_SLAVE1,
        CONTIG_GAP
    } contig_sel_e;

endpackage

// ==== design/tcdm_addr_decoder.sv ====
// Address decoder that maps a TCDM address to a region and to a contiguous slave index

`timescale 1ns/1ps

`include "soc_interconnect_params.svh"

module tcdm_addr_decoder (
    input  logic [`SOC_ADDR_WIDTH-1:0]        addr_i,
    output soc_interconnect_pkg::region_e     region_o,
    output soc_interconnect_pkg::contig_sel_e contig_sel_o
);

    // Region match against the bounds of the fixed map
    always_comb begin
        region_o = soc_interconnect_pkg::REGION_ERROR;
        if (addr_i >= `SOC_INTLV_START && addr_i <= `SOC_INTLV_END) begin
            region_o = soc_interconnect_pkg::REGION_INTLV;
        end else if (addr_i >= `SOC_CONTIG_START && addr_i <= `SOC_CONTIG_END) begin
            region_o = soc_interconnect_pkg::REGION_CONTIG;
        end
    end

    // Slave match inside the contiguous region
    // Anything that fits neither range is a gap and lands on the error slave
    // The select is only looked at when the region is contiguous
    always_comb begin
        contig_sel_o = soc_interconnect_pkg::CONTIG_GAP;
        if (addr_i >= `SOC_CONTIG0_START && addr_i <= `SOC_CONTIG0_END) begin
            contig_sel_o = soc_interconnect_pkg::CONTIG_SLAVE0;
        end else if (addr_i >= `SOC_CONTIG1_START && addr_i <= `SOC_CONTIG1_END) begin
            contig_sel_o = soc_interconnect_pkg::CONTIG_SLAVE1;
        end
    end

endmodule

// ==== design/tcdm_crossbar.sv ====
// N-by-M TCDM crossbar with combinational round-robin arbitration per slave and registered routing

`timescale 1ns/1ps

module tcdm_crossbar #(
    parameter int unsigned NR_MASTERS = 3,
    parameter int unsigned NR_SLAVES  = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t master_req_i [NR_MASTERS],
    input  logic [1:0]                      master_sel_i [NR_MASTERS],
    output soc_interconnect_pkg::tcdm_rsp_t master_rsp_o [NR_MASTERS],
    output soc_interconnect_pkg::tcdm_req_t slave_req_o  [NR_SLAVES],
    input  soc_interconnect_pkg::tcdm_rsp_t slave_rsp_i  [NR_SLAVES]
);

    // Width of a master index
    localparam int unsigned MW = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    logic [NR_MASTERS-1:0] req_vec   [NR_SLAVES];
    logic [MW-1:0]         winner    [NR_SLAVES];
    logic [NR_SLAVES-1:0]  found;
    logic [NR_SLAVES-1:0]  xfer;
    logic [MW-1:0]         rr_q      [NR_SLAVES];
    logic [MW-1:0]         winner_q  [NR_SLAVES];
    logic [NR_SLAVES-1:0]  granted_q;

    ////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////

    // Each slave scans the masters starting at its pointer and takes the first requester
    always_comb begin
        int unsigned idx;
        idx = 0;
        for (int s = 0; s < NR_SLAVES; s++) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                req_vec[s][m] = master_req_i[m].req && (master_sel_i[m] == 2'(s));
            end
            winner[s] = rr_q[s];
            found[s]  = 1'b0;
            for (int k = 0; k < NR_MASTERS; k++) begin
                idx = (int'(rr_q[s]) + k) % NR_MASTERS;
                if (!found[s] && req_vec[s][idx]) begin
                    winner[s] = MW'(idx);
                    found[s]  = 1'b1;
                end
            end
            // The winner's payload goes out and req rises only when some master asks
            slave_req_o[s]     = master_req_i[winner[s]];
            slave_req_o[s].req = found[s];
        end
    end

    // A transfer happens where a forwarded request meets the slave's grant
    always_comb begin
        for (int s = 0; s < NR_SLAVES; s++) begin
            xfer[s] = found[s] && slave_rsp_i[s].gnt;
        end
    end

    // Pointer moves one past the winner, and the winner is kept for the response
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            granted_q <= '0;
            for (int s = 0; s < NR_SLAVES; s++) begin
                rr_q[s]     <= '0;
                winner_q[s] <= '0;
            end
        end else begin
            granted_q <= xfer;
            for (int s = 0; s < NR_SLAVES; s++) begin
                if (xfer[s]) begin
                    winner_q[s] <= winner[s];
                    if (winner[s] == MW'(NR_MASTERS - 1)) begin
                        rr_q[s] <= '0;
                    end else begin
                        rr_q[s] <= winner[s] + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////

    // Grant goes back only to the current winner
    // Response data goes to the master granted one cycle earlier
    // A master is granted by one slave per cycle at most, so routes never collide
    always_comb begin
        for (int m = 0; m < NR_MASTERS; m++) begin
            master_rsp_o[m] = '0;
        end
        for (int s = 0; s < NR_SLAVES; s++) begin
            if (xfer[s]) begin
                master_rsp_o[winner[s]].gnt = 1'b1;
            end
            if (granted_q[s]) begin
                master_rsp_o[winner_q[s]].r_valid = slave_rsp_i[s].r_valid;
                master_rsp_o[winner_q[s]].r_opc   = slave_rsp_i[s].r_opc;
                master_rsp_o[winner_q[s]].r_rdata = slave_rsp_i[s].r_rdata;
            end
        end
    end

endmodule

// ==== design/tcdm_demux.sv ====
// Region demultiplexer for one master, with a local error slave and registered response steering

`timescale 1ns/1ps

module tcdm_demux #(
    parameter bit ALLOW_CONTIG = 1'b1
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t   master_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t   master_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t   intlv_req_o,
    input  soc_interconnect_pkg::tcdm_rsp_t   intlv_rsp_i,
    output soc_interconnect_pkg::tcdm_req_t   contig_req_o,
    output soc_interconnect_pkg::contig_sel_e contig_sel_o,
    input  soc_interconnect_pkg::tcdm_rsp_t   contig_rsp_i
);

    soc_interconnect_pkg::region_e   dec_region;
    soc_interconnect_pkg::region_e   region;
    soc_interconnect_pkg::region_e   route_q;
    soc_interconnect_pkg::tcdm_req_t err_req;
    soc_interconnect_pkg::tcdm_rsp_t err_rsp;
    soc_interconnect_pkg::tcdm_rsp_t rsp_sel;
    logic                            gnt;

    tcdm_addr_decoder i_addr_decoder (
        .addr_i       (master_req_i.add),
        .region_o     (dec_region),
        .contig_sel_o (contig_sel_o)
    );

    // For an interleaved-only master the contiguous region is forbidden
    always_comb begin
        region = dec_region;
        if (!ALLOW_CONTIG && dec_region == soc_interconnect_pkg::REGION_CONTIG) begin
            region = soc_interconnect_pkg::REGION_ERROR;
        end
    end

    ////////////////////////////////////////
    // Request path
    ////////////////////////////////////////

    // All outputs carry the payload, but req rises only on the decoded region
    always_comb begin
        intlv_req_o      = master_req_i;
        contig_req_o     = master_req_i;
        err_req          = master_req_i;
        intlv_req_o.req  = master_req_i.req && (region == soc_interconnect_pkg::REGION_INTLV);
        contig_req_o.req = master_req_i.req && (region == soc_interconnect_pkg::REGION_CONTIG);
        err_req.req      = master_req_i.req && (region == soc_interconnect_pkg::REGION_ERROR);
    end

    tcdm_error_slave i_error_slave (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .slave_req_i (err_req),
        .slave_rsp_o (err_rsp)
    );

    // Grant comes back in the same cycle from the region being addressed now
    always_comb begin
        case (region)
            soc_interconnect_pkg::REGION_INTLV:  gnt = intlv_rsp_i.gnt;
            soc_interconnect_pkg::REGION_CONTIG: gnt = contig_rsp_i.gnt;
            default:                             gnt = err_rsp.gnt;
        endcase
    end

    ////////////////////////////////////////
    // Response path
    ////////////////////////////////////////

    // The route of a granted request selects the response of the next cycle
    // A new request may be granted meanwhile, since the route updates on the same edge
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            route_q <= soc_interconnect_pkg::REGION_ERROR;
        end else if (master_req_i.req && gnt) begin
            route_q <= region;
        end
    end

    always_comb begin
        case (route_q)
            soc_interconnect_pkg::REGION_INTLV:  rsp_sel = intlv_rsp_i;
            soc_interconnect_pkg::REGION_CONTIG: rsp_sel = contig_rsp_i;
            default:                             rsp_sel = err_rsp;
        endcase
        master_rsp_o     = rsp_sel;
        master_rsp_o.gnt = gnt;
    end

endmodule

// ==== design/tcdm_error_slave.sv ====
// Error slave that grants at once and answers one cycle later with the error word and opc set

`timescale 1ns/1ps

`include "soc_interconnect_params.svh"

module tcdm_error_slave (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t slave_req_i,
    output soc_interconnect_pkg::tcdm_rsp_t slave_rsp_o
);

    // Set for one cycle after each granted edge
    logic rsp_pending_q;

    // Grant equals req, so every request transfers on the edge it is seen
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_pending_q <= 1'b0;
        end else begin
            rsp_pending_q <= slave_req_i.req;
        end
    end

    // Back-to-back requests give back-to-back error responses
    always_comb begin
        slave_rsp_o.gnt     = slave_req_i.req;
        slave_rsp_o.r_valid = rsp_pending_q;
        slave_rsp_o.r_opc   = rsp_pending_q;
        slave_rsp_o.r_rdata = `SOC_ERROR_WORD;
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset generator for the interconnect testbench

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock with a 50 percent duty cycle
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset is held low for the first few rising edges and released just after one
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== testbench/tb_soc_interconnect.sv ====
// Table-driven testbench for the TCDM interconnect with bank and contiguous memory models

`timescale 1ns/1ps

`include "soc_interconnect_params.svh"

// Memory model behind one slave port that grants unless stalled and answers one cycle later
module slave_mem_model (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  soc_interconnect_pkg::tcdm_req_t req_i,
    output soc_interconnect_pkg::tcdm_rsp_t rsp_o
);

    logic [31:0] mem [logic [29:0]];
    logic        valid_q;
    logic [31:0] rdata_q;
    logic        gnt;

    // Unwritten words read back a pattern built from the whole word address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:2], 2'b00, addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return fill_word({addr[31:2], 2'b00});
    endfunction

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  be
    );
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    always_comb begin
        gnt           = req_i.req && !stall_i;
        rsp_o.gnt     = gnt;
        rsp_o.r_valid = valid_q;
        rsp_o.r_opc   = 1'b0;
        rsp_o.r_rdata = rdata_q;
    end

    // Response of a granted request comes exactly one cycle after the grant
    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            rdata_q <= '0;
        end else begin
            valid_q <= gnt;
            if (gnt && req_i.wen) begin
                rdata_q <= read_word(req_i.add);
            end else if (gnt) begin
                mem[req_i.add[31:2]] = merge_bytes(read_word(req_i.add), req_i.wdata, req_i.be);
            end
        end
    end

endmodule

module tb_soc_interconnect;

    localparam int PERIOD_NS      = 100;
    localparam int DRIVE_DELAY_NS = 1;
    localparam int NR_STEPS       = 11;
    localparam int NR_LANES       = `SOC_NR_MASTERS + `SOC_NR_INTLV_ONLY;
    localparam int NR_MODELS      = `SOC_NR_BANKS + `SOC_NR_CONTIG;
    localparam int TIMEOUT_NS     = NR_STEPS * 50 * PERIOD_NS;
    localparam int SEED           = 72;
    localparam logic [2:0] TARGET_NONE = 3'd6;

    // One lane request of a step and what it should produce
    typedef struct packed {
        logic        active;
        logic [31:0] addr;
        logic        wen;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        exp_opc;
        logic [2:0]  target;   // Banks are 0 to 3, contiguous slaves 4 and 5
    } lane_op_t;

    logic                            clk;
    logic                            rst_n;
    soc_interconnect_pkg::tcdm_req_t master_req     [`SOC_NR_MASTERS];
    soc_interconnect_pkg::tcdm_rsp_t master_rsp     [`SOC_NR_MASTERS];
    soc_interconnect_pkg::tcdm_req_t intlv_only_req [`SOC_NR_INTLV_ONLY];
    soc_interconnect_pkg::tcdm_rsp_t intlv_only_rsp [`SOC_NR_INTLV_ONLY];
    soc_interconnect_pkg::tcdm_req_t bank_req       [`SOC_NR_BANKS];
    soc_interconnect_pkg::tcdm_rsp_t bank_rsp       [`SOC_NR_BANKS];
    soc_interconnect_pkg::tcdm_req_t contig_req     [`SOC_NR_CONTIG];
    soc_interconnect_pkg::tcdm_rsp_t contig_rsp     [`SOC_NR_CONTIG];
    soc_interconnect_pkg::tcdm_req_t lane_req       [NR_LANES];
    soc_interconnect_pkg::tcdm_rsp_t lane_rsp       [NR_LANES];
    logic [NR_MODELS-1:0]            stall;
    string                           step_name      [NR_STEPS];
    lane_op_t                        step_op        [NR_STEPS][NR_LANES];
    logic [31:0]                     ref_mem        [logic [29:0]];
    int                              nr_defined;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) i_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_interconnect uut (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .master_req_i     (master_req),
        .master_rsp_o     (master_rsp),
        .intlv_only_req_i (intlv_only_req),
        .intlv_only_rsp_o (intlv_only_rsp),
        .bank_req_o       (bank_req),
        .bank_rsp_i       (bank_rsp),
        .contig_req_o     (contig_req),
        .contig_rsp_i     (contig_rsp)
    );

    // Lanes 0 and 1 are the full-access masters and lane 2 is the interleaved-only one
    for (genvar i = 0; i < `SOC_NR_MASTERS; i++) begin : gen_master_lane
        assign master_req[i] = lane_req[i];
        assign lane_rsp[i]   = master_rsp[i];
    end
    for (genvar j = 0; j < `SOC_NR_INTLV_ONLY; j++) begin : gen_intlv_only_lane
        assign intlv_only_req[j]            = lane_req[`SOC_NR_MASTERS+j];
        assign lane_rsp[`SOC_NR_MASTERS+j] = intlv_only_rsp[j];
    end

    for (genvar k = 0; k < `SOC_NR_BANKS; k++) begin : gen_bank
        slave_mem_model i_bank (
            .clk_i   (clk),
            .rst_n_i (rst_n),
            .stall_i (stall[k]),
            .req_i   (bank_req[k]),
            .rsp_o   (bank_rsp[k])
        );
    end
    for (genvar k = 0; k < `SOC_NR_CONTIG; k++) begin : gen_contig
        slave_mem_model i_contig (
            .clk_i   (clk),
            .rst_n_i (rst_n),
            .stall_i (stall[`SOC_NR_BANKS+k]),
            .req_i   (contig_req[k]),
            .rsp_o   (contig_rsp[k])
        );
    end

    ////////////////////////////////////////
    // Checks and reference model
    ////////////////////////////////////////

    task automatic check_value(
        input string       tag,
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        assert (actual === expected) else begin
            $display("error %s %s: expected %h, actual %h", tag, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopping at the first failing check");
        end
    endtask

    task automatic require_true(input bit cond, input string tag, input string msg);
        assert (cond) else begin
            $display("%s: %s", tag, msg);
            $display("TEST FAIL");
            $fatal(1, "stopping at the first failing check");
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:2], 2'b00, addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    // Read data that the testbench expects from the memory behind the interconnect
    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return fill_word({addr[31:2], 2'b00});
    endfunction

    // True when the given slave port transfers this address in the current cycle
    function automatic bit slave_took(input logic [2:0] target, input logic [31:0] addr);
        int t;
        t = int'(target);
        if (t < `SOC_NR_BANKS) begin
            return bank_req[t].req && bank_rsp[t].gnt && bank_req[t].add == addr;
        end
        t = t - `SOC_NR_BANKS;
        return contig_req[t].req && contig_rsp[t].gnt && contig_req[t].add == addr;
    endfunction

    function automatic bit any_slave_addressed(input logic [31:0] addr);
        bit hit;
        hit = 1'b0;
        for (int k = 0; k < `SOC_NR_BANKS; k++) begin
            hit = hit || (bank_req[k].req && bank_req[k].add == addr);
        end
        for (int k = 0; k < `SOC_NR_CONTIG; k++) begin
            hit = hit || (contig_req[k].req && contig_req[k].add == addr);
        end
        return hit;
    endfunction

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////

    function automatic lane_op_t read_op(
        input logic [31:0] addr,
        input logic [31:0] exp_rdata,
        input logic        exp_opc,
        input logic [2:0]  target
    );
        return '{1'b1, addr, 1'b1, 32'h0, exp_rdata, exp_opc, target};
    endfunction

    // An error answer carries the error word for a write as well
    function automatic lane_op_t write_op(
        input logic [31:0] addr,
        input logic [31:0] wdata,
        input logic        exp_opc,
        input logic [2:0]  target
    );
        logic [31:0] exp_rdata;
        exp_rdata = exp_opc ? `SOC_ERROR_WORD : 32'h0;
        return '{1'b1, addr, 1'b0, wdata, exp_rdata, exp_opc, target};
    endfunction

    function automatic lane_op_t idle_op();
        return '0;
    endfunction

    task automatic add_step(input string name, input lane_op_t op0, input lane_op_t op1,
                            input lane_op_t op2);
        step_name[nr_defined]  = name;
        step_op[nr_defined][0] = op0;
        step_op[nr_defined][1] = op1;
        step_op[nr_defined][2] = op2;
        nr_defined++;
    endtask

    // Four consecutive words go to banks 0 to 3, then contiguous, gap, forbidden and contention
    task automatic build_table();
        add_step("intlv_write", write_op(32'h1C00_0100, 32'hA000_0100, 1'b0, 3'd0),
                 write_op(32'h1C00_0104, 32'hA000_0104, 1'b0, 3'd1),
                 write_op(32'h1C00_0108, 32'hA000_0108, 1'b0, 3'd2));
        add_step("intlv_write_last", write_op(32'h1C00_010C, 32'hA000_010C, 1'b0, 3'd3),
                 idle_op(), idle_op());
        add_step("intlv_read", read_op(32'h1C00_010C, 32'hA000_010C, 1'b0, 3'd3),
                 read_op(32'h1C00_0100, 32'hA000_0100, 1'b0, 3'd0),
                 read_op(32'h1C00_0104, 32'hA000_0104, 1'b0, 3'd1));
        add_step("intlv_read_last", idle_op(), idle_op(),
                 read_op(32'h1C00_0108, 32'hA000_0108, 1'b0, 3'd2));
        add_step("contig_write", write_op(32'h1C01_0040, 32'hC000_0040, 1'b0, 3'd4),
                 write_op(32'h1C01_4080, 32'hC100_4080, 1'b0, 3'd5), idle_op());
        add_step("contig_read", read_op(32'h1C01_4080, 32'hC100_4080, 1'b0, 3'd5),
                 read_op(32'h1C01_0040, 32'hC000_0040, 1'b0, 3'd4), idle_op());
        add_step("contig_gap", read_op(32'h1C01_8000, `SOC_ERROR_WORD, 1'b1, TARGET_NONE),
                 idle_op(), idle_op());
        add_step("forbidden", read_op(32'h2000_0000, `SOC_ERROR_WORD, 1'b1, TARGET_NONE),
                 write_op(32'h0000_0010, 32'hDEAD_BEEF, 1'b1, TARGET_NONE),
                 read_op(32'h1C01_0000, `SOC_ERROR_WORD, 1'b1, TARGET_NONE));
        add_step("contention_write", write_op(32'h1C00_0214, 32'hB000_0214, 1'b0, 3'd1),
                 write_op(32'h1C00_0224, 32'hB000_0224, 1'b0, 3'd1),
                 write_op(32'h1C00_0234, 32'hB000_0234, 1'b0, 3'd1));
        add_step("contention_read", read_op(32'h1C00_0214, 32'hB000_0214, 1'b0, 3'd1),
                 read_op(32'h1C00_0224, 32'hB000_0224, 1'b0, 3'd1),
                 read_op(32'h1C00_0234, 32'hB000_0234, 1'b0, 3'd1));
        add_step("contention_mixed", read_op(32'h1C00_0224, 32'hB000_0224, 1'b0, 3'd1),
                 read_op(32'h1C00_0104, 32'hA000_0104, 1'b0, 3'd1),
                 read_op(32'h1C01_0040, `SOC_ERROR_WORD, 1'b1, TARGET_NONE));
    endtask

    ////////////////////////////////////////
    // Lane driver
    ////////////////////////////////////////

    // Holds the request until gnt, then checks the response of the following cycle
    task automatic run_lane(input int step, input int lane);
        lane_op_t                        op;
        soc_interconnect_pkg::tcdm_req_t req;
        string                           tag;
        op  = step_op[step][lane];
        tag = $sformatf("%s lane %0d", step_name[step], lane);
        if (op.active) begin
            req.req        = 1'b1;
            req.add        = op.addr;
            req.wen        = op.wen;
            req.be         = '1;
            req.wdata      = op.wdata;
            lane_req[lane] = req;
            // Sampling at the falling edge sees settled combinational grants
            do begin
                @(negedge clk);
                require_true(!lane_rsp[lane].r_valid, tag, "r_valid rose while waiting for gnt");
            end while (!lane_rsp[lane].gnt);
            if (op.target == TARGET_NONE) begin
                require_true(!any_slave_addressed(op.addr), tag,
                             "error access reached a slave port");
            end else begin
                require_true(slave_took(op.target, op.addr), tag,
                             "request missed its slave port");
            end
            if (!op.wen && !op.exp_opc) begin
                ref_mem[op.addr[31:2]] = op.wdata;
            end
            @(posedge clk);
            #DRIVE_DELAY_NS;
            lane_req[lane] = '0;
            @(negedge clk);
            check_value(tag, "r_valid", 32'd1, 32'(lane_rsp[lane].r_valid));
            check_value(tag, "r_opc", 32'(op.exp_opc), 32'(lane_rsp[lane].r_opc));
            if (op.wen || op.exp_opc) begin
                check_value(tag, "r_rdata", op.exp_rdata, lane_rsp[lane].r_rdata);
            end
            if (op.wen && !op.exp_opc) begin
                check_value(tag, "reference data", ref_read(op.addr),
                            lane_rsp[lane].r_rdata);
            end
        end
    endtask

    ////////////////////////////////////////
    // Processes
    ////////////////////////////////////////

    // Each model stalls its grant in about one cycle out of four
    initial begin
        void'($urandom(SEED));
        stall = '0;
        forever begin
            @(posedge clk);
            for (int k = 0; k < NR_MODELS; k++) begin
                stall[k] <= ($urandom % 4) == 0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all steps completed");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        for (int l = 0; l < NR_LANES; l++) begin
            lane_req[l] = '0;
        end
        nr_defined = 0;
        build_table();
        wait (rst_n === 1'b1);
        // All three lanes of a step start together, so contention is real
        for (int s = 0; s < nr_defined; s++) begin
            @(posedge clk);
            #DRIVE_DELAY_NS;
            fork
                run_lane(s, 0);
                run_lane(s, 1);
                run_lane(s, 2);
            join
        end
        $display("TEST PASS");
        $finish;
    end

endmodule
